// File: Bender.yml
package:
  name: eth_rx_subsystem

sources:
  # Design, in compile order
  - include_dirs:
      - source
    files:
      - source/eth_rx_pkg.sv
      - source/eth_bus_if.sv
      - source/packet_cdc_fifo.sv
      - source/eth_rx_cdc.sv
      - source/eth_rx_stats_wb.sv
      - source/eth_rx_subsystem.sv

  # Testbench
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_eth_rx_subsystem.sv

// File: project.f
+incdir+source
source/eth_rx_pkg.sv
source/eth_bus_if.sv
source/packet_cdc_fifo.sv
source/eth_rx_cdc.sv
source/eth_rx_stats_wb.sv
source/eth_rx_subsystem.sv
verif/tb_eth_rx_subsystem.sv

// File: source/eth_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

// Frame bus between MAC, crossing and layer 2
interface eth_bus_if;

	logic                   start;
	logic                   data_valid;
	logic [`ETH_BV_W-1:0]   bytes_valid;
	logic [`ETH_DATA_W-1:0] data;
	logic                   commit;
	logic                   drop;

	// Receiving end of the MAC stream
	modport mac (
		input start, data_valid, bytes_valid, data, commit, drop
	);

	// Driving end toward the layer 2 decoder
	modport l2 (
		output start, data_valid, bytes_valid, data, commit, drop
	);

endinterface

`default_nettype wire

// File: source/eth_rx_cdc.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

module eth_rx_cdc (
	input  wire logic gmii_rxc,
	input  wire logic sys_clk,
	input  wire logic rst_n,
	eth_bus_if.mac    mac_bus,
	eth_bus_if.l2     l2_bus
);

	import eth_rx_pkg::*;

	logic                  fifo_wr_en;
	fifo_word_t            fifo_wr_data;
	logic                  fifo_rd_en;
	fifo_word_t            fifo_rd_data;
	logic [`ETH_FIFO_AW:0] fifo_rd_size;
	pop_state_e            pop_state;
	logic                  rd_is_delim;
	logic                  rd_empty;
	logic                  fwd_word;

	// Frames are separated by an all zero word
	packet_cdc_fifo i_packet_cdc_fifo (
		.wr_clk      (gmii_rxc),
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.wr_en       (fifo_wr_en),
		.wr_data     (fifo_wr_data),
		.wr_commit   (mac_bus.commit),
		.wr_rollback (mac_bus.drop),
		.rd_en       (fifo_rd_en),
		.rd_data     (fifo_rd_data),
		.rd_size     (fifo_rd_size)
	);

	//////////////////////////////////////////////////
	// Push side
	//////////////////////////////////////////////////

	always_comb begin
		if (mac_bus.start) begin
			// Delimiter ahead of the first word
			fifo_wr_en   = 1'b1;
			fifo_wr_data = '0;
		end else begin
			fifo_wr_en               = mac_bus.data_valid;
			fifo_wr_data.bytes_valid = mac_bus.bytes_valid;
			fifo_wr_data.data        = mac_bus.data;
		end
	end

	//////////////////////////////////////////////////
	// Pop side
	//////////////////////////////////////////////////

	assign rd_is_delim = (fifo_rd_data == '0);
	assign rd_empty    = (fifo_rd_size == '0);

	// First word after start is always payload
	assign fwd_word = (pop_state == PACKET_0) ||
		((pop_state == PACKET_1) && !rd_is_delim);

	// FIFO pops, issued in the same cycle as the decision
	always_comb begin
		case (pop_state)
			WAIT_HDR_1: fifo_rd_en = 1'b1;
			IDLE:       fifo_rd_en = !rd_empty;
			PACKET_0:   fifo_rd_en = !rd_empty;
			// Stop once the next delimiter shows up
			PACKET_1:   fifo_rd_en = !rd_is_delim && !rd_empty;
			default:    fifo_rd_en = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			pop_state         <= WAIT_HDR_0;
			l2_bus.start      <= 1'b0;
			l2_bus.data_valid <= 1'b0;
			l2_bus.commit     <= 1'b0;
		end else begin
			l2_bus.start      <= 1'b0;
			l2_bus.data_valid <= fwd_word;
			l2_bus.commit     <= 1'b0;

			case (pop_state)
				// Resync after reset, drop words up to a delimiter
				WAIT_HDR_0: begin
					if (!rd_empty) begin
						pop_state <= WAIT_HDR_1;
					end
				end
				// Pop one word
				WAIT_HDR_1: begin
					pop_state <= WAIT_HDR_2;
				end
				WAIT_HDR_2: begin
					pop_state <= rd_is_delim ? IDLE : WAIT_HDR_0;
				end

				// Delimiter already consumed
				// Anything published is a whole frame
				IDLE: begin
					if (!rd_empty) begin
						l2_bus.start <= 1'b1;
						pop_state    <= PACKET_0;
					end
				end

				// First word arriving
				PACKET_0: begin
					pop_state <= rd_empty ? PACKET_2 : PACKET_1;
				end

				// One word per clock until a delimiter or empty
				PACKET_1: begin
					if (rd_is_delim) begin
						// Next frame already waiting
						l2_bus.commit <= 1'b1;
						pop_state     <= IDLE;
					end else if (rd_empty) begin
						pop_state <= PACKET_2;
					end
				end

				// Last word out, nothing behind it yet
				PACKET_2: begin
					l2_bus.commit <= 1'b1;
					pop_state     <= WAIT_HDR_0;
				end

				default: pop_state <= WAIT_HDR_0;
			endcase
		end
	end

	// Payload follows data_valid
	always_ff @(posedge sys_clk) begin
		if (fwd_word) begin
			l2_bus.bytes_valid <= fifo_rd_data.bytes_valid;
			l2_bus.data        <= fifo_rd_data.data;
		end
	end

	// Layer 2 never sees a dropped frame
	assign l2_bus.drop = 1'b0;

endmodule

`default_nettype wire

// File: source/eth_rx_params.svh
`ifndef ETH_RX_PARAMS_SVH
`define ETH_RX_PARAMS_SVH

//////////////////////////////////////////////////
// Receive path dimensions
//////////////////////////////////////////////////

// One MAC word per clock
`define ETH_DATA_W 32

// Count of valid bytes in a word, 1 to 4
`define ETH_BV_W 3

// Room for two maximum frames plus delimiters
`define ETH_FIFO_DEPTH 1024
`define ETH_FIFO_AW 10

// Byte address of the counter registers
`define ETH_WB_AW 4

`endif

// File: source/eth_rx_pkg.sv
`default_nettype none

`include "eth_rx_params.svh"

package eth_rx_pkg;

	// One FIFO entry
	// All zero marks the start of a frame
	typedef struct packed {
		logic [`ETH_BV_W-1:0]   bytes_valid;
		logic [`ETH_DATA_W-1:0] data;
	} fifo_word_t;

	// Pop side of the receive crossing
	typedef enum logic [2:0] {
		WAIT_HDR_0,
		WAIT_HDR_1,
		WAIT_HDR_2,
		IDLE,
		PACKET_0,
		PACKET_1,
		PACKET_2
	} pop_state_e;

	// Counter register map
	typedef enum logic [`ETH_WB_AW-1:0] {
		REG_FRAMES = 'h0,
		REG_BYTES  = 'h4
	} stats_reg_e;

endpackage

`default_nettype wire

// File: source/eth_rx_stats_wb.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

module eth_rx_stats_wb (
	input  wire logic                  sys_clk,
	input  wire logic                  rst_n,
	eth_bus_if.l2                      l2_bus,
	input  wire logic                  wb_cyc,
	input  wire logic                  wb_stb,
	input  wire logic                  wb_we,
	input  wire logic [`ETH_WB_AW-1:0] wb_adr,
	input  wire logic [31:0]           wb_dat_w,
	output logic [31:0]                wb_dat_r,
	output logic                       wb_ack
);

	import eth_rx_pkg::*;

	logic [31:0] frame_count;
	logic [31:0] byte_count;
	logic        wb_req;
	logic        wb_clear;

	// New strobe, ack drops for a cycle in between
	assign wb_req   = wb_cyc && wb_stb && !wb_ack;
	assign wb_clear = wb_req && wb_we;

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			frame_count <= '0;
			byte_count  <= '0;
		end else if (wb_clear) begin
			// Either address clears both
			frame_count <= '0;
			byte_count  <= '0;
		end else begin
			if (l2_bus.commit) begin
				frame_count <= frame_count + 1'b1;
			end
			if (l2_bus.data_valid) begin
				byte_count <= byte_count + 32'(l2_bus.bytes_valid);
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus slave
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_req;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wb_req) begin
			if (wb_we) begin
				// Write cycles echo the written word
				wb_dat_r <= wb_dat_w;
			end else begin
				case (wb_adr)
					REG_FRAMES: wb_dat_r <= frame_count;
					REG_BYTES:  wb_dat_r <= byte_count;
					default:    wb_dat_r <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/eth_rx_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

module eth_rx_subsystem (
	input  wire logic                   gmii_rxc,
	input  wire logic                   sys_clk,
	input  wire logic                   rst_n,
	// MAC side, gmii_rxc domain
	input  wire logic                   mac_start,
	input  wire logic                   mac_data_valid,
	input  wire logic [`ETH_BV_W-1:0]   mac_bytes_valid,
	input  wire logic [`ETH_DATA_W-1:0] mac_data,
	input  wire logic                   mac_commit,
	input  wire logic                   mac_drop,
	// Layer 2 side, sys_clk domain
	output logic                        rx_start,
	output logic                        rx_data_valid,
	output logic [`ETH_BV_W-1:0]        rx_bytes_valid,
	output logic [`ETH_DATA_W-1:0]      rx_data,
	output logic                        rx_commit,
	// Counter port
	input  wire logic                   wb_cyc,
	input  wire logic                   wb_stb,
	input  wire logic                   wb_we,
	input  wire logic [`ETH_WB_AW-1:0]  wb_adr,
	input  wire logic [31:0]            wb_dat_w,
	output logic [31:0]                 wb_dat_r,
	output logic                        wb_ack
);

	eth_bus_if mac_bus ();
	eth_bus_if l2_bus ();

	// Pack MAC ports
	assign mac_bus.start       = mac_start;
	assign mac_bus.data_valid  = mac_data_valid;
	assign mac_bus.bytes_valid = mac_bytes_valid;
	assign mac_bus.data        = mac_data;
	assign mac_bus.commit      = mac_commit;
	assign mac_bus.drop        = mac_drop;

	eth_rx_cdc i_eth_rx_cdc (
		.gmii_rxc (gmii_rxc),
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.mac_bus  (mac_bus.mac),
		.l2_bus   (l2_bus.l2)
	);

	// Counters watch the layer 2 stream
	eth_rx_stats_wb i_eth_rx_stats_wb (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.l2_bus   (l2_bus.l2),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	// Unpack layer 2 bus
	assign rx_start       = l2_bus.start;
	assign rx_data_valid  = l2_bus.data_valid;
	assign rx_bytes_valid = l2_bus.bytes_valid;
	assign rx_data        = l2_bus.data;
	assign rx_commit      = l2_bus.commit;

endmodule

`default_nettype wire

// File: source/packet_cdc_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

module packet_cdc_fifo (
	input  wire logic                   wr_clk,
	input  wire logic                   sys_clk,
	input  wire logic                   rst_n,
	input  wire logic                   wr_en,
	input  wire eth_rx_pkg::fifo_word_t wr_data,
	input  wire logic                   wr_commit,
	input  wire logic                   wr_rollback,
	input  wire logic                   rd_en,
	output eth_rx_pkg::fifo_word_t      rd_data,
	output logic [`ETH_FIFO_AW:0]       rd_size
);

	import eth_rx_pkg::*;

	localparam int DEPTH = `ETH_FIFO_DEPTH;
	localparam int AW    = `ETH_FIFO_AW;
	// Extra bit tells full from empty
	localparam int PTR_W = AW + 1;

	fifo_word_t mem [DEPTH];

	// Read domain pointers, the Gray copy also feeds the write side
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_gray;
	logic [PTR_W-1:0] rd_cg_meta;
	logic [PTR_W-1:0] rd_cg_sync;
	logic [PTR_W-1:0] rd_cg_last;
	logic [PTR_W-1:0] rd_committed;

	function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
		logic [PTR_W-1:0] b;
		b[PTR_W-1] = g[PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	//////////////////////////////////////////////////
	// Write domain
	//////////////////////////////////////////////////

	logic             wr_rst_meta;
	logic             wr_rst_n;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] wr_committed;
	logic [PTR_W-1:0] wr_commit_gray;
	logic [PTR_W-1:0] wr_rg_meta;
	logic [PTR_W-1:0] wr_rg_sync;
	logic [PTR_W-1:0] wr_rd_ptr;
	logic [PTR_W-1:0] wr_base;
	logic             wr_full;
	logic             wr_push;

	// Reset brought into the MAC clock
	always_ff @(posedge wr_clk) begin
		wr_rst_meta <= rst_n;
		wr_rst_n    <= wr_rst_meta;
	end

	// Rollback takes effect before a write in the same cycle
	assign wr_base   = wr_rollback ? wr_committed : wr_ptr;
	assign wr_rd_ptr = gray2bin(wr_rg_sync);
	// Read pointer lags here, so full is conservative
	assign wr_full   = (wr_base - wr_rd_ptr) == PTR_W'(DEPTH);
	assign wr_push   = wr_en && !wr_full;

	always_ff @(posedge wr_clk) begin
		if (!wr_rst_n) begin
			wr_ptr         <= '0;
			wr_committed   <= '0;
			wr_commit_gray <= '0;
			wr_rg_meta     <= '0;
			wr_rg_sync     <= '0;
		end else begin
			wr_ptr <= wr_push ? wr_base + 1'b1 : wr_base;
			// Publish everything written before this cycle
			if (wr_commit) begin
				wr_committed <= wr_ptr;
			end
			wr_commit_gray <= bin2gray(wr_committed);
			wr_rg_meta     <= rd_gray;
			wr_rg_sync     <= wr_rg_meta;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_push) begin
			mem[wr_base[AW-1:0]] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read domain
	//////////////////////////////////////////////////

	// Commit can move the pointer by a whole frame
	// Take a value only once two samples agree
	// Commits are at least three MAC clocks apart
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			rd_ptr       <= '0;
			rd_gray      <= '0;
			rd_cg_meta   <= '0;
			rd_cg_sync   <= '0;
			rd_cg_last   <= '0;
			rd_committed <= '0;
		end else begin
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Steps by one at most, safe to cross as is
			rd_gray    <= bin2gray(rd_ptr);
			rd_cg_meta <= wr_commit_gray;
			rd_cg_sync <= rd_cg_meta;
			rd_cg_last <= rd_cg_sync;
			if (rd_cg_sync == rd_cg_last) begin
				rd_committed <= gray2bin(rd_cg_sync);
			end
		end
	end

	// Read data one cycle after rd_en
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	// Published words not yet popped
	assign rd_size = rd_committed - rd_ptr;

endmodule

`default_nettype wire

// File: verif/tb_eth_rx_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "eth_rx_params.svh"

module tb_eth_rx_subsystem;

	import eth_rx_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'hc02b_8e38;

	logic                   sys_clk;
	logic                   gmii_rxc;
	logic                   rst_n;
	logic                   mac_start;
	logic                   mac_data_valid;
	logic [`ETH_BV_W-1:0]   mac_bytes_valid;
	logic [`ETH_DATA_W-1:0] mac_data;
	logic                   mac_commit;
	logic                   mac_drop;
	logic                   rx_start;
	logic                   rx_data_valid;
	logic [`ETH_BV_W-1:0]   rx_bytes_valid;
	logic [`ETH_DATA_W-1:0] rx_data;
	logic                   rx_commit;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_we;
	logic [`ETH_WB_AW-1:0]  wb_adr;
	logic [31:0]            wb_dat_w;
	logic [31:0]            wb_dat_r;
	logic                   wb_ack;

	// Random source and watchdog budget
	logic [31:0] lfsr = LFSR_SEED;
	int          gen_words = 0;
	int          cycle_count = 0;

	// Frame under construction on the MAC side
	logic [31:0] frame_data [24];
	logic [2:0]  frame_bv [24];

	// Model of committed frames, in commit order
	logic [31:0] exp_data [$];
	logic [2:0]  exp_bv [$];
	int          exp_len [$];
	int          exp_total = 0;
	logic [31:0] exp_frames = '0;
	logic [31:0] exp_bytes = '0;

	// Layer 2 monitor state
	bit in_frame = 1'b0;
	int cur_len = 0;
	int cur_seen = 0;
	int commit_wait = 0;
	int commits_seen = 0;

	eth_rx_subsystem i_eth_rx_subsystem (
		.gmii_rxc        (gmii_rxc),
		.sys_clk         (sys_clk),
		.rst_n           (rst_n),
		.mac_start       (mac_start),
		.mac_data_valid  (mac_data_valid),
		.mac_bytes_valid (mac_bytes_valid),
		.mac_data        (mac_data),
		.mac_commit      (mac_commit),
		.mac_drop        (mac_drop),
		.rx_start        (rx_start),
		.rx_data_valid   (rx_data_valid),
		.rx_bytes_valid  (rx_bytes_valid),
		.rx_data         (rx_data),
		.rx_commit       (rx_commit),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack)
	);

	//////////////////////////////////////////////////
	// Clocks
	//////////////////////////////////////////////////

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// MAC clock runs faster than the system side
	initial begin
		gmii_rxc = 1'b0;
		forever #4 gmii_rxc = ~gmii_rxc;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Committed frame goes to the model, word by word
	// Byte count is the sum of bytes_valid over its words
	function automatic void record_frame(input int len);
		for (int i = 0; i < len; i++) begin
			exp_data.push_back(frame_data[i]);
			exp_bv.push_back(frame_bv[i]);
			exp_bytes = exp_bytes + 32'(frame_bv[i]);
		end
		exp_len.push_back(len);
		exp_frames = exp_frames + 1;
		exp_total++;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Called right after a gmii_rxc edge, returns right after one
	task automatic send_frame(input bit back_to_back, input bit force_drop);
		int len;
		int gap;
		bit drop;
		len = int'(take_bits(5) % 24) + 1;
		for (int i = 0; i < len; i++) begin
			frame_data[i] = take_bits(32);
			// Full words except the last one
			frame_bv[i]   = (i == len - 1) ? 3'(take_bits(2) + 1) : 3'd4;
		end
		drop = force_drop || (!back_to_back && take_bits(2) == 0);
		gen_words += len + 1;
		mac_start <= 1'b1;
		@(posedge gmii_rxc);
		mac_start <= 1'b0;
		for (int i = 0; i < len; i++) begin
			// Occasional hole inside the frame
			if (!back_to_back && take_bits(3) == 0) begin
				mac_data_valid <= 1'b0;
				@(posedge gmii_rxc);
			end
			mac_data_valid  <= 1'b1;
			mac_data        <= frame_data[i];
			mac_bytes_valid <= frame_bv[i];
			@(posedge gmii_rxc);
		end
		mac_data_valid <= 1'b0;
		if (drop) begin
			mac_drop <= 1'b1;
		end else begin
			mac_commit <= 1'b1;
			record_frame(len);
		end
		@(posedge gmii_rxc);
		mac_commit <= 1'b0;
		mac_drop   <= 1'b0;
		if (!back_to_back) begin
			gap = int'(take_bits(2));
			repeat (gap) @(posedge gmii_rxc);
		end
	endtask

	// Single classic cycle, ack expected one cycle after the strobe
	task automatic wb_cycle(input logic we, input logic [`ETH_WB_AW-1:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int wait_cycles;
		@(posedge sys_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		wait_cycles = 0;
		@(negedge sys_clk);
		while (!wb_ack && wait_cycles < 16) begin
			@(negedge sys_clk);
			wait_cycles++;
		end
		check_value("wb_ack", 1, wb_ack);
		check_value("wb_ack latency", 1, wait_cycles);
		rdata = wb_dat_r;
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge sys_clk);
		check_value("wb_ack after cycle", 0, wb_ack);
	endtask

	// Wait until every committed frame has been seen on layer 2
	task automatic drain_frames();
		while (commits_seen < exp_total) begin
			@(posedge sys_clk);
		end
		repeat (4) @(posedge sys_clk);
		check_value("words left in model", 0, exp_data.size());
	endtask

	//////////////////////////////////////////////////
	// Layer 2 scoreboard
	//////////////////////////////////////////////////

	always @(negedge sys_clk) begin
		if (rst_n) begin
			if (rx_commit) begin
				check_value("rx_commit with open frame", 1, in_frame);
				check_value("words before rx_commit", cur_len, cur_seen);
				in_frame = 1'b0;
				commits_seen++;
			end
			// Commit follows the last word within two cycles
			if (in_frame && cur_seen == cur_len) begin
				commit_wait++;
				check_value("rx_commit delay ok", 1, commit_wait < 2);
			end
			if (rx_start) begin
				check_value("rx_start with open frame", 0, in_frame);
				check_value("rx_start with frame pending", 1, exp_len.size() != 0);
				in_frame    = 1'b1;
				cur_len     = exp_len.pop_front();
				cur_seen    = 0;
				commit_wait = 0;
			end else if (in_frame && cur_seen < cur_len) begin
				// Words back to back once the frame is open
				check_value("rx_data_valid", 1, rx_data_valid);
			end
			if (rx_data_valid) begin
				check_value("rx_data_valid in frame", 1, in_frame && cur_seen < cur_len);
				check_value("rx_data", exp_data.pop_front(), rx_data);
				check_value("rx_bytes_valid", 32'(exp_bv.pop_front()), 32'(rx_bytes_valid));
				cur_seen++;
			end
		end
	end

	// Budget grows with the traffic generated so far
	initial begin
		while (cycle_count <= 40 * gen_words + 2000) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("Timeout after %0d sys_clk cycles with frames still outstanding", cycle_count);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] rd_val;
		rst_n           = 1'b0;
		mac_start       = 1'b0;
		mac_data_valid  = 1'b0;
		mac_bytes_valid = '0;
		mac_data        = '0;
		mac_commit      = 1'b0;
		mac_drop        = 1'b0;
		wb_cyc          = 1'b0;
		wb_stb          = 1'b0;
		wb_we           = 1'b0;
		wb_adr          = '0;
		wb_dat_w        = '0;
		repeat (16) @(posedge sys_clk);
		rst_n <= 1'b1;
		// Let the MAC side reset synchronizer release
		repeat (8) @(posedge sys_clk);

		// Quiet outputs and cleared counters after reset
		@(negedge sys_clk);
		check_value("rx_start", 0, rx_start);
		check_value("rx_data_valid", 0, rx_data_valid);
		check_value("rx_commit", 0, rx_commit);
		check_value("wb_ack", 0, wb_ack);
		wb_cycle(1'b0, REG_FRAMES, '0, rd_val);
		check_value("frame counter", 0, rd_val);
		wb_cycle(1'b0, REG_BYTES, '0, rd_val);
		check_value("byte counter", 0, rd_val);

		// Random traffic with drops, then back to back commits
		@(posedge gmii_rxc);
		for (int k = 0; k < 20; k++) begin
			send_frame(1'b0, k == 3);
		end
		for (int k = 0; k < 8; k++) begin
			send_frame(1'b1, 1'b0);
		end
		drain_frames();
		wb_cycle(1'b0, REG_FRAMES, '0, rd_val);
		check_value("frame counter", exp_frames, rd_val);
		wb_cycle(1'b0, REG_BYTES, '0, rd_val);
		check_value("byte counter", exp_bytes, rd_val);
		// Unmapped address
		wb_cycle(1'b0, 4'h8, '0, rd_val);
		check_value("unmapped register", 0, rd_val);

		// Any write clears both counters
		wb_cycle(1'b1, REG_BYTES, 32'h1234_5678, rd_val);
		exp_frames = '0;
		exp_bytes  = '0;
		wb_cycle(1'b0, REG_FRAMES, '0, rd_val);
		check_value("frame counter", 0, rd_val);
		wb_cycle(1'b0, REG_BYTES, '0, rd_val);
		check_value("byte counter", 0, rd_val);

		// Second burst counted on its own
		@(posedge gmii_rxc);
		for (int k = 0; k < 12; k++) begin
			send_frame(1'b0, 1'b0);
		end
		drain_frames();
		wb_cycle(1'b0, REG_FRAMES, '0, rd_val);
		check_value("frame counter", exp_frames, rd_val);
		wb_cycle(1'b0, REG_BYTES, '0, rd_val);
		check_value("byte counter", exp_bytes, rd_val);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
